//--- common/afu_pkg.sv
package afu_pkg;

	// ------------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------------
	localparam int LINE_W         = 512;
	localparam int ADDR_W         = 58;
	// one bit wider than the read-number field
	localparam int BATCH_W        = 10;
	localparam int LINES_PER_READ = 4;
	localparam int ENG_ADDR_W     = 32;

	// handshake line layout
	localparam int TAG0_BIT  = 480;
	localparam int TAG1_BIT  = 482;
	localparam int BATCH_LSB = 448;

	// status codes, placed in bits 511:480 of a status line
	localparam logic [31:0] STAT_POLLED   = 32'd128;
	localparam logic [31:0] STAT_LOADED   = 32'd256;
	localparam logic [31:0] STAT_RUN_DONE = 32'd512;
	localparam logic [31:0] STAT_FINISHED = 32'd16;

	// ------------------------------------------------------------------------
	// records
	// ------------------------------------------------------------------------
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [ADDR_W-1:0] addr_t;

	typedef struct packed {
		addr_t k;
		addr_t l;
	} rd_pair_t;

	// fence set means a write fence, addr and data are then unused
	typedef struct packed {
		logic  fence;
		addr_t addr;
		line_t data;
	} wr_req_t;

	typedef enum logic [7:0] {
		IDLE      = 8'b0000_0001,
		POLL_REQ  = 8'b0000_0010,
		POLL_WAIT = 8'b0000_0100,
		LOAD      = 8'b0000_1000,
		RUN       = 8'b0001_0000,
		OUTPUT    = 8'b0010_0000,
		FENCE     = 8'b0100_0000,
		FINAL     = 8'b1000_0000
	} batch_state_e;

endpackage

//--- hw/req_fifo.sv
module req_fifo #(
	parameter type payload_t = logic,
	parameter int FIFO_DEPTH = 4
) (
	input  logic     CLK_200M,
	input  logic     reset_n,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output logic     head_valid,
	output payload_t head
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	payload_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full    = count == (PTR_W + 1)'(FIFO_DEPTH);
	assign do_pop  = pop && head_valid;
	// a full queue still takes a push when the head leaves in the same cycle
	assign do_push = push && (!full || do_pop);

	assign head_valid = count != '0;
	assign head       = mem[rd_ptr];

	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge CLK_200M) begin
		if (do_push) mem[wr_ptr] <= push_data;
	end

endmodule

//--- hw/rd_pair_port.sv
module rd_pair_port (
	input  logic              CLK_200M,
	input  logic              reset_n,
	input  logic              head_valid,
	input  afu_pkg::rd_pair_t head,
	output logic              pop,
	input  logic              rd_almostfull,
	output logic              tx_rd_valid,
	output afu_pkg::addr_t    tx_rd_addr,
	input  logic              rx_rd_valid,
	input  afu_pkg::line_t    rx_data,
	output logic              pair_valid,
	output afu_pkg::line_t    line_k,
	output afu_pkg::line_t    line_l
);

	logic issue_l;
	logic recv_l;
	logic issue_go;

	// one address per allowed cycle, k first
	assign issue_go = head_valid && !rd_almostfull;
	assign pop      = issue_go && issue_l;

	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			issue_l     <= 1'b0;
			recv_l      <= 1'b0;
			tx_rd_valid <= 1'b0;
			pair_valid  <= 1'b0;
		end else begin
			tx_rd_valid <= issue_go;
			if (issue_go) issue_l <= ~issue_l;
			// responses return in order, so they alternate k, l
			pair_valid <= rx_rd_valid && recv_l;
			if (rx_rd_valid) recv_l <= ~recv_l;
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (issue_go) begin
			tx_rd_addr <= issue_l ? head.l : head.k;
		end
		if (rx_rd_valid) begin
			if (recv_l) begin
				line_l <= rx_data;
			end else begin
				line_k <= rx_data;
			end
		end
	end

endmodule

//--- hw/batch_ctrl/batch_fsm.sv
module batch_fsm (
	input  logic                               CLK_200M,
	input  logic                               reset_n,
	input  logic                               rd_almostfull,
	input  logic                               wr_almostfull,
	// configuration
	input  logic                               core_start,
	input  afu_pkg::addr_t                     hand_ptr,
	input  afu_pkg::addr_t                     input_base,
	input  afu_pkg::addr_t                     bwt_base,
	input  afu_pkg::addr_t                     output_base,
	// read responses
	input  logic                               pair_valid,
	input  afu_pkg::line_t                     line_k,
	input  afu_pkg::line_t                     line_l,
	// request queues
	output logic                               rd_push,
	output afu_pkg::rd_pair_t                  rd_req,
	output logic                               wr_push,
	output afu_pkg::wr_req_t                   wr_req,
	// alignment engine
	output logic                               eng_reset_n,
	output logic                               load_valid,
	output afu_pkg::line_t                     load_data,
	output logic [afu_pkg::BATCH_W-1:0]        batch_size,
	input  logic                               read_load_done,
	input  logic                               dram_valid,
	input  logic [afu_pkg::ENG_ADDR_W-1:0]     addr_k,
	input  logic [afu_pkg::ENG_ADDR_W-1:0]     addr_l,
	output logic                               dram_get,
	output afu_pkg::line_t                     cl_k,
	output afu_pkg::line_t                     cl_l,
	output logic                               output_permit,
	input  logic                               output_request,
	input  afu_pkg::line_t                     output_data,
	input  logic                               output_valid,
	input  logic                               output_finish
);

	import afu_pkg::*;

	localparam int LOAD_W = BATCH_W + $clog2(LINES_PER_READ);

	batch_state_e state;
	batch_state_e nxt;

	addr_t hand_ptr_q;
	addr_t input_base_q;
	addr_t bwt_base_q;
	addr_t output_base_q;

	logic              stall;
	logic              pace;
	logic              rd_go;
	logic              polling_tag;
	logic              tag_hit;
	logic              poll_hit;
	logic              state_evt;
	logic              evt_q;
	logic [LOAD_W-1:0] load_ptr;
	logic [LOAD_W-1:0] load_total;
	addr_t             out_ptr;
	logic              pend_valid;
	rd_pair_t          pend_pair;
	logic              rd_fire;
	rd_pair_t          rd_next;
	logic              wr_fire;
	wr_req_t           wr_next;

	function automatic wr_req_t status_req(input addr_t where, input logic [31:0] code);
		wr_req_t req;
		req = '0;
		req.addr = where;
		req.data[LINE_W-1 -: 32] = code;
		return req;
	endfunction

	assign load_total = LOAD_W'(batch_size) * LOAD_W'(LINES_PER_READ);
	assign tag_hit    = polling_tag ? line_l[TAG1_BIT] : line_l[TAG0_BIT];
	// the port drains one pair every two cycles, so read pushes are spaced
	assign rd_go      = !stall && !pace;

	assign eng_reset_n = state != IDLE;
	// engine only sends output lines while the host can take them
	assign output_permit = state == OUTPUT && !stall;

	// event that ends the current state, held in evt_q until acted on
	always_comb begin
		case (state)
			POLL_WAIT: state_evt = pair_valid;
			LOAD:      state_evt = read_load_done;
			RUN:       state_evt = output_request;
			OUTPUT:    state_evt = output_finish;
			default:   state_evt = 1'b0;
		endcase
	end

	// ------------------------------------------------------------------------
	// next state and queue pushes
	// ------------------------------------------------------------------------
	always_comb begin
		nxt     = state;
		rd_fire = 1'b0;
		rd_next = pend_pair;
		wr_fire = 1'b0;
		wr_next = status_req(hand_ptr_q, STAT_FINISHED);
		case (state)
			IDLE: begin
				if (core_start) nxt = POLL_REQ;
			end
			POLL_REQ: begin
				if (rd_go) begin
					rd_fire = 1'b1;
					rd_next = '{k: hand_ptr_q, l: hand_ptr_q};
					nxt     = POLL_WAIT;
				end
			end
			POLL_WAIT: begin
				if (evt_q && !stall) begin
					if (poll_hit) begin
						wr_fire = 1'b1;
						wr_next = status_req(hand_ptr_q, STAT_POLLED);
						nxt     = LOAD;
					end else begin
						nxt = POLL_REQ;
					end
				end
			end
			LOAD: begin
				// identical k and l, the response pair carries one read line
				if (rd_go && load_ptr < load_total) begin
					rd_fire = 1'b1;
					rd_next = '{k: input_base_q + addr_t'(load_ptr),
						l: input_base_q + addr_t'(load_ptr)};
				end
				if (evt_q && !stall) begin
					wr_fire = 1'b1;
					wr_next = status_req(hand_ptr_q, STAT_LOADED);
					nxt     = RUN;
				end
			end
			RUN: begin
				if (rd_go && pend_valid) rd_fire = 1'b1;
				if (evt_q && !stall) begin
					wr_fire = 1'b1;
					wr_next = status_req(hand_ptr_q, STAT_RUN_DONE);
					nxt     = OUTPUT;
				end
			end
			OUTPUT: begin
				if (!stall) begin
					if (output_valid) begin
						wr_fire = 1'b1;
						wr_next = '{fence: 1'b0, addr: output_base_q + out_ptr,
							data: output_data};
					end else if (evt_q) begin
						nxt = FENCE;
					end
				end
			end
			FENCE: begin
				if (!stall) begin
					wr_fire = 1'b1;
					wr_next = '{fence: 1'b1, addr: '0, data: '0};
					nxt     = FINAL;
				end
			end
			FINAL: begin
				if (!stall) begin
					wr_fire = 1'b1;
					nxt     = IDLE;
				end
			end
			default: nxt = IDLE;
		endcase
	end

	// ------------------------------------------------------------------------
	// control registers
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			state       <= IDLE;
			stall       <= 1'b0;
			pace        <= 1'b0;
			evt_q       <= 1'b0;
			poll_hit    <= 1'b0;
			polling_tag <= 1'b0;
			batch_size  <= '0;
			load_ptr    <= '0;
			out_ptr     <= '0;
			pend_valid  <= 1'b0;
			rd_push     <= 1'b0;
			wr_push     <= 1'b0;
			load_valid  <= 1'b0;
			dram_get    <= 1'b0;
		end else begin
			state   <= nxt;
			stall   <= rd_almostfull | wr_almostfull;
			pace    <= rd_fire;
			rd_push <= rd_fire;
			wr_push <= wr_fire;

			if (nxt != state) begin
				evt_q <= 1'b0;
			end else if (state_evt) begin
				evt_q <= 1'b1;
			end

			// handshake line check
			if (state == POLL_WAIT && pair_valid) begin
				poll_hit <= tag_hit;
				if (tag_hit) batch_size <= line_l[BATCH_LSB +: BATCH_W];
			end
			// next batch expects the other tag bit
			if (state == POLL_WAIT && nxt == LOAD) polling_tag <= ~polling_tag;

			if (state != LOAD) begin
				load_ptr <= '0;
			end else if (rd_fire) begin
				load_ptr <= load_ptr + 1'b1;
			end

			if (state != OUTPUT) begin
				out_ptr <= '0;
			end else if (wr_fire) begin
				out_ptr <= out_ptr + 1'b1;
			end

			// one lookup may wait here, lookups can start before RUN is reached
			if (state == IDLE) begin
				pend_valid <= 1'b0;
			end else if (dram_valid) begin
				pend_valid <= 1'b1;
			end else if (state == RUN && rd_fire) begin
				pend_valid <= 1'b0;
			end

			// responses are forwarded even while stalled
			load_valid <= state == LOAD && pair_valid;
			dram_get   <= state == RUN && pair_valid;
		end
	end

	// payload registers
	always_ff @(posedge CLK_200M) begin
		hand_ptr_q    <= hand_ptr;
		input_base_q  <= input_base;
		bwt_base_q    <= bwt_base;
		output_base_q <= output_base;
		if (rd_fire) rd_req <= rd_next;
		if (wr_fire) wr_req <= wr_next;
		if (dram_valid) begin
			pend_pair <= '{k: bwt_base_q + addr_t'(addr_k[ENG_ADDR_W-1:4]),
				l: bwt_base_q + addr_t'(addr_l[ENG_ADDR_W-1:4])};
		end
		if (pair_valid) begin
			load_data <= line_k;
			cl_k      <= line_k;
			cl_l      <= line_l;
		end
	end

endmodule

//--- hw/afu_core.sv
module afu_core #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                               CLK_200M,
	input  logic                               reset_n,
	// host read channel
	input  logic                               rd_almostfull,
	output logic                               tx_rd_valid,
	output afu_pkg::addr_t                     tx_rd_addr,
	input  logic                               rx_rd_valid,
	input  afu_pkg::line_t                     rx_data,
	// host write channel
	input  logic                               wr_almostfull,
	output logic                               tx_wr_valid,
	output afu_pkg::addr_t                     tx_wr_addr,
	output afu_pkg::line_t                     tx_data,
	output logic                               tx_fence_valid,
	// configuration
	input  logic                               core_start,
	input  afu_pkg::addr_t                     hand_ptr,
	input  afu_pkg::addr_t                     input_base,
	input  afu_pkg::addr_t                     bwt_base,
	input  afu_pkg::addr_t                     output_base,
	// alignment engine
	output logic                               eng_reset_n,
	output logic                               load_valid,
	output afu_pkg::line_t                     load_data,
	output logic [afu_pkg::BATCH_W-1:0]        batch_size,
	input  logic                               read_load_done,
	input  logic                               dram_valid,
	input  logic [afu_pkg::ENG_ADDR_W-1:0]     addr_k,
	input  logic [afu_pkg::ENG_ADDR_W-1:0]     addr_l,
	output logic                               dram_get,
	output afu_pkg::line_t                     cl_k,
	output afu_pkg::line_t                     cl_l,
	output logic                               output_permit,
	input  logic                               output_request,
	input  afu_pkg::line_t                     output_data,
	input  logic                               output_valid,
	input  logic                               output_finish
);

	import afu_pkg::*;

	logic     rd_push;
	rd_pair_t rd_req;
	logic     rq_head_valid;
	rd_pair_t rq_head;
	logic     rq_pop;
	logic     wr_push;
	wr_req_t  wr_req;
	logic     wq_head_valid;
	wr_req_t  wq_head;
	logic     wq_pop;
	logic     wr_af_q;
	logic     pair_valid;
	line_t    line_k;
	line_t    line_l;

	// ------------------------------------------------------------------------
	// write channel, head goes straight to the host
	// ------------------------------------------------------------------------
	// previous-cycle write almost-full
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			wr_af_q <= 1'b0;
		end else begin
			wr_af_q <= wr_almostfull;
		end
	end

	assign wq_pop         = wq_head_valid && !wr_almostfull && !wr_af_q;
	assign tx_wr_valid    = wq_pop;
	assign tx_fence_valid = wq_pop && wq_head.fence;
	assign tx_wr_addr     = wq_head.addr;
	assign tx_data        = wq_head.data;

	req_fifo #(
		.payload_t  (wr_req_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_wr_fifo (
		.CLK_200M   (CLK_200M),
		.reset_n    (reset_n),
		.push       (wr_push),
		.push_data  (wr_req),
		.pop        (wq_pop),
		.head_valid (wq_head_valid),
		.head       (wq_head)
	);

	// ------------------------------------------------------------------------
	// read channel
	// ------------------------------------------------------------------------
	req_fifo #(
		.payload_t  (rd_pair_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_rd_fifo (
		.CLK_200M   (CLK_200M),
		.reset_n    (reset_n),
		.push       (rd_push),
		.push_data  (rd_req),
		.pop        (rq_pop),
		.head_valid (rq_head_valid),
		.head       (rq_head)
	);

	rd_pair_port u_rd_port (
		.CLK_200M      (CLK_200M),
		.reset_n       (reset_n),
		.head_valid    (rq_head_valid),
		.head          (rq_head),
		.pop           (rq_pop),
		.rd_almostfull (rd_almostfull),
		.tx_rd_valid   (tx_rd_valid),
		.tx_rd_addr    (tx_rd_addr),
		.rx_rd_valid   (rx_rd_valid),
		.rx_data       (rx_data),
		.pair_valid    (pair_valid),
		.line_k        (line_k),
		.line_l        (line_l)
	);

	batch_fsm u_batch_fsm (
		.CLK_200M       (CLK_200M),
		.reset_n        (reset_n),
		.rd_almostfull  (rd_almostfull),
		.wr_almostfull  (wr_almostfull),
		.core_start     (core_start),
		.hand_ptr       (hand_ptr),
		.input_base     (input_base),
		.bwt_base       (bwt_base),
		.output_base    (output_base),
		.pair_valid     (pair_valid),
		.line_k         (line_k),
		.line_l         (line_l),
		.rd_push        (rd_push),
		.rd_req         (rd_req),
		.wr_push        (wr_push),
		.wr_req         (wr_req),
		.eng_reset_n    (eng_reset_n),
		.load_valid     (load_valid),
		.load_data      (load_data),
		.batch_size     (batch_size),
		.read_load_done (read_load_done),
		.dram_valid     (dram_valid),
		.addr_k         (addr_k),
		.addr_l         (addr_l),
		.dram_get       (dram_get),
		.cl_k           (cl_k),
		.cl_l           (cl_l),
		.output_permit  (output_permit),
		.output_request (output_request),
		.output_data    (output_data),
		.output_valid   (output_valid),
		.output_finish  (output_finish)
	);

endmodule

//--- test/afu_core_sva.sv
module afu_core_sva (
	input logic       CLK_200M,
	input logic       reset_n,
	input logic       rd_almostfull,
	input logic       tx_rd_valid,
	input logic       wr_almostfull,
	input logic       tx_wr_valid,
	input logic       output_permit,
	input logic [7:0] fsm_state
);

	timeunit 1ns;
	timeprecision 1ps;

	import afu_pkg::*;

	// no read request after an almost-full cycle
	rd_af_rule: assert property (@(posedge CLK_200M) disable iff (!reset_n)
		tx_rd_valid |-> !$past(rd_almostfull))
		else $error("tx_rd_valid high after rd_almostfull");

	wr_af_rule: assert property (@(posedge CLK_200M) disable iff (!reset_n)
		tx_wr_valid |-> !$past(wr_almostfull))
		else $error("tx_wr_valid high after wr_almostfull");

	permit_rule: assert property (@(posedge CLK_200M) disable iff (!reset_n)
		output_permit |-> fsm_state == OUTPUT)
		else $error("output_permit high outside the OUTPUT state");

endmodule

bind afu_core afu_core_sva u_sva (
	.CLK_200M      (CLK_200M),
	.reset_n       (reset_n),
	.rd_almostfull (rd_almostfull),
	.tx_rd_valid   (tx_rd_valid),
	.wr_almostfull (wr_almostfull),
	.tx_wr_valid   (tx_wr_valid),
	.output_permit (output_permit),
	.fsm_state     (u_batch_fsm.state)
);

//--- test/tb_afu_core.sv
module tb_afu_core;

	timeunit 1ns;
	timeprecision 1ps;

	import afu_pkg::*;

	localparam int NUM_TESTS = 4;

	logic CLK_200M = 1'b0;
	logic reset_n;
	logic rd_almostfull, tx_rd_valid, rx_rd_valid;
	logic wr_almostfull, tx_wr_valid, tx_fence_valid;
	addr_t tx_rd_addr, tx_wr_addr;
	line_t rx_data, tx_data;
	logic core_start;
	addr_t hand_ptr, input_base, bwt_base, output_base;
	logic eng_reset_n, load_valid, read_load_done, dram_valid, dram_get;
	line_t load_data, cl_k, cl_l, output_data;
	logic [BATCH_W-1:0] batch_size;
	logic [ENG_ADDR_W-1:0] addr_k, addr_l;
	logic output_permit, output_request, output_valid, output_finish;

	// stimulus table, one column per test
	string t_name    [NUM_TESTS] = '{"basic", "tag_miss", "stall", "stall_miss"};
	bit    t_tag_ok  [NUM_TESTS] = '{1'b1, 1'b0, 1'b1, 1'b0};
	int    t_bsize   [NUM_TESTS] = '{1, 2, 2, 1};
	int    t_lookups [NUM_TESTS] = '{2, 3, 3, 2};
	int    t_outs    [NUM_TESTS] = '{2, 3, 3, 1};
	bit    t_rand_af [NUM_TESTS] = '{1'b0, 1'b0, 1'b1, 1'b1};

	integer  seed = 10707;
	int      errors = 0;
	string   cur_name = "reset";
	bit      af_rand = 1'b0;
	int      resp_wait = 0;
	line_t   hand_line;
	line_t   rsp_q[$];
	addr_t   rd_log[$];
	wr_req_t wr_log[$];

	afu_core #(.FIFO_DEPTH(4)) uut (.*);

	always #4 CLK_200M = ~CLK_200M;

	// memory content, the address repeated across the line
	function automatic line_t line_of(input addr_t a);
		if (a == hand_ptr) return hand_line;
		return line_t'({9{a}});
	endfunction

	function automatic line_t status_line(input logic [31:0] code);
		return {code, 480'b0};
	endfunction

	function automatic addr_t rd_at(input int i);
		if (i >= rd_log.size()) return '1;
		return rd_log[i];
	endfunction

	task automatic check_eq(input string what, input logic [575:0] exp, input logic [575:0] act);
		assert (exp === act) else begin
			$display("Mismatch %s %s: expected %h, actual %h", cur_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string msg);
		assert (cond) else begin
			$display("test %s: %s", cur_name, msg);
			errors++;
		end
	endtask

	// host side, requests logged on the rising edge
	always @(posedge CLK_200M) begin
		if (reset_n && tx_rd_valid) begin
			rd_log.push_back(tx_rd_addr);
			rsp_q.push_back(line_of(tx_rd_addr));
		end
		if (reset_n && tx_wr_valid) begin
			wr_log.push_back('{fence: tx_fence_valid, addr: tx_wr_addr, data: tx_data});
		end
	end

	// in-order responses after a random delay, plus random almost-full
	always @(negedge CLK_200M) begin
		logic [31:0] r;
		r = $random(seed);
		rd_almostfull = af_rand && r[1:0] == 2'd0;
		wr_almostfull = af_rand && r[3:2] == 2'd0;
		if (resp_wait > 0) begin
			resp_wait--;
			rx_rd_valid = 1'b0;
		end else if (rsp_q.size() > 0) begin
			rx_rd_valid = 1'b1;
			rx_data = rsp_q.pop_front();
			resp_wait = int'(r[5:4]);
		end else begin
			rx_rd_valid = 1'b0;
		end
	end

	// watchdog, limit scales with the table
	initial begin
		int units;
		units = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			units += 10 + 8 * t_bsize[t] + 4 * t_lookups[t] + t_outs[t] + (t_tag_ok[t] ? 0 : 8);
		end
		#(units * 60 * 8);
		$display("watchdog: the run did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int base_w, base_r, nloads, hand_reads, idx, err0, n_pass;
		bit parity;
		logic [ENG_ADDR_W-1:0] ak [$];
		logic [ENG_ADDR_W-1:0] al [$];
		wr_req_t exp_wr [$];

		reset_n = 1'b0;
		rd_almostfull = 1'b0;
		wr_almostfull = 1'b0;
		rx_rd_valid = 1'b0;
		rx_data = '0;
		core_start = 1'b0;
		hand_ptr = addr_t'(58'h100);
		input_base = addr_t'(58'h1000);
		bwt_base = addr_t'(58'h20000);
		output_base = addr_t'(58'h3000);
		read_load_done = 1'b0;
		dram_valid = 1'b0;
		addr_k = '0;
		addr_l = '0;
		output_request = 1'b0;
		output_data = '0;
		output_valid = 1'b0;
		output_finish = 1'b0;
		hand_line = '0;
		parity = 1'b0;
		n_pass = 0;
		repeat (5) @(negedge CLK_200M);
		reset_n = 1'b1;
		@(negedge CLK_200M);
		check_true(!tx_rd_valid && !tx_wr_valid && !tx_fence_valid && !load_valid
			&& !output_permit && !eng_reset_n, "an output was high after reset");

		for (int t = 0; t < NUM_TESTS; t++) begin
			cur_name = t_name[t];
			err0 = errors;
			base_w = wr_log.size();
			base_r = rd_log.size();
			@(posedge CLK_200M);
			af_rand = t_rand_af[t];
			hand_line = '0;
			hand_line[BATCH_LSB +: BATCH_W] = BATCH_W'(t_bsize[t]);
			// a miss sets only the tag bit of the other parity
			if (t_tag_ok[t] ^ parity) hand_line[TAG0_BIT] = 1'b1;
			else hand_line[TAG1_BIT] = 1'b1;
			@(negedge CLK_200M);
			core_start = 1'b1;
			@(negedge CLK_200M);
			core_start = 1'b0;

			if (!t_tag_ok[t]) begin
				while (rd_log.size() - base_r < 4) @(negedge CLK_200M);
				check_true(wr_log.size() == base_w, "write seen before the tag matched");
				hand_line[TAG0_BIT] = ~parity;
				hand_line[TAG1_BIT] = parity;
			end

			// load phase
			nloads = 0;
			while (nloads < 4 * t_bsize[t]) begin
				@(negedge CLK_200M);
				if (load_valid) begin
					check_eq("load_data", 576'(line_of(input_base + addr_t'(nloads))),
						576'(load_data));
					nloads++;
				end
			end
			check_eq("batch_size", 576'(t_bsize[t]), 576'(batch_size));
			check_true(eng_reset_n, "engine held in reset during the batch");
			read_load_done = 1'b1;
			@(negedge CLK_200M);
			read_load_done = 1'b0;

			// run phase, one lookup at a time
			ak.delete();
			al.delete();
			for (int j = 0; j < t_lookups[t]; j++) begin
				ak.push_back(32'(((j * 37 + t * 11 + 3) << 4) | (j & 15)));
				al.push_back(32'(((j * 37 + t * 11 + 3) << 4) | (j & 15)) + 32'h2530);
				addr_k = ak[j];
				addr_l = al[j];
				dram_valid = 1'b1;
				@(negedge CLK_200M);
				dram_valid = 1'b0;
				while (!dram_get) @(negedge CLK_200M);
				check_eq("cl_k", 576'(line_of(bwt_base + addr_t'(ak[j] >> 4))), 576'(cl_k));
				check_eq("cl_l", 576'(line_of(bwt_base + addr_t'(al[j] >> 4))), 576'(cl_l));
			end
			while (wr_log.size() < base_w + 2) @(negedge CLK_200M);
			output_request = 1'b1;
			@(negedge CLK_200M);
			output_request = 1'b0;

			// output phase, lines only while permitted
			idx = 0;
			while (idx < t_outs[t]) begin
				@(negedge CLK_200M);
				output_valid = output_permit;
				if (output_permit) begin
					output_data = line_t'({16{32'h0C0D_E000 + 32'(t * 256 + idx)}});
					idx++;
				end
			end
			@(negedge CLK_200M);
			output_valid = 1'b0;
			output_finish = 1'b1;
			@(negedge CLK_200M);
			output_finish = 1'b0;
			while (wr_log.size() < base_w + 5 + t_outs[t]) @(negedge CLK_200M);
			check_true(!eng_reset_n, "engine not put back in reset after the batch");

			// expected write sequence
			exp_wr.delete();
			exp_wr.push_back('{fence: 1'b0, addr: hand_ptr, data: status_line(STAT_POLLED)});
			exp_wr.push_back('{fence: 1'b0, addr: hand_ptr, data: status_line(STAT_LOADED)});
			exp_wr.push_back('{fence: 1'b0, addr: hand_ptr, data: status_line(STAT_RUN_DONE)});
			for (int n = 0; n < t_outs[t]; n++) begin
				exp_wr.push_back('{fence: 1'b0, addr: output_base + addr_t'(n),
					data: line_t'({16{32'h0C0D_E000 + 32'(t * 256 + n)}})});
			end
			exp_wr.push_back('{fence: 1'b1, addr: '0, data: '0});
			exp_wr.push_back('{fence: 1'b0, addr: hand_ptr, data: status_line(STAT_FINISHED)});
			for (int n = 0; n < exp_wr.size(); n++) begin
				check_eq($sformatf("write %0d", n), 576'(exp_wr[n]), 576'(wr_log[base_w + n]));
			end

			// read sequence, polls first
			idx = base_r;
			hand_reads = 0;
			while (idx < rd_log.size() && rd_log[idx] == hand_ptr) begin
				hand_reads++;
				idx++;
			end
			check_true(hand_reads >= (t_tag_ok[t] ? 2 : 4), "too few handshake reads");
			for (int n = 0; n < 8 * t_bsize[t]; n++) begin
				check_eq("load read", 576'(input_base + addr_t'(n / 2)), 576'(rd_at(idx)));
				idx++;
			end
			for (int j = 0; j < t_lookups[t]; j++) begin
				check_eq("k read", 576'(bwt_base + addr_t'(ak[j] >> 4)), 576'(rd_at(idx)));
				check_eq("l read", 576'(bwt_base + addr_t'(al[j] >> 4)), 576'(rd_at(idx + 1)));
				idx += 2;
			end
			check_true(idx == rd_log.size(), "unexpected extra reads");

			parity = ~parity;
			if (errors == err0) begin
				n_pass++;
				$display("test %s: ok", cur_name);
			end else begin
				$display("test %s: failed with %0d errors", cur_name, errors - err0);
			end
		end

		$display("summary: %0d tests passed, %0d failed, %0d errors", n_pass,
			NUM_TESTS - n_pass, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- vlog.f
common/afu_pkg.sv
hw/req_fifo.sv
hw/rd_pair_port.sv
hw/batch_ctrl/batch_fsm.sv
hw/afu_core.sv
test/afu_core_sva.sv
test/tb_afu_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_afu_core -o sim_afu \
	&& ./obj_dir/sim_afu | tee /dev/stderr | grep -q '^>>> PASS$' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
